// ==== hw/ctrl_pkg.sv ====
//================================================
// Control-side constants for the cabinet glue
// Scancodes are PS/2 set 2 and the arrows need the E0 prefix
//================================================
`default_nettype none

package ctrl_pkg;

	// Held key vector from the keyboard decoder
	localparam int KEY_W      = 8;
	localparam int KEY_FIRE   = 0;
	localparam int KEY_START1 = 1;
	localparam int KEY_START2 = 2;
	localparam int KEY_COIN   = 3;
	localparam int KEY_UP     = 4;
	localparam int KEY_DOWN   = 5;
	localparam int KEY_LEFT   = 6;
	localparam int KEY_RIGHT  = 7;

	// Make codes, the four arrows count only after SC_EXTENDED
	localparam logic [7:0] SC_SPACE    = 8'h29;
	localparam logic [7:0] SC_1        = 8'h16;
	localparam logic [7:0] SC_2        = 8'h1E;
	localparam logic [7:0] SC_5        = 8'h2E;
	localparam logic [7:0] SC_UP       = 8'h75;
	localparam logic [7:0] SC_DOWN     = 8'h72;
	localparam logic [7:0] SC_LEFT     = 8'h6B;
	localparam logic [7:0] SC_RIGHT    = 8'h74;
	localparam logic [7:0] SC_EXTENDED = 8'hE0;
	localparam logic [7:0] SC_BREAK    = 8'hF0;

	// PS/2 frame is start, eight data, parity, stop
	localparam int PS2_BITS   = 11;
	localparam int PS2_WDOG_W = 16;

	// Joystick word from the I/O controller
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	// Status and buttons bit positions
	localparam int ST_RESET      = 0;
	localparam int ST_ROTATE     = 2;
	localparam int ST_MENU_RESET = 6;
	localparam int BTN_RESET     = 1;

	// Player control word, coin in the top bit down to right in bit 0
	localparam int CTRL_W     = 7;
	localparam int CTRL_RIGHT = 0;
	localparam int CTRL_LEFT  = 1;
	localparam int CTRL_DOWN  = 2;
	localparam int CTRL_UP    = 3;
	localparam int CTRL_FIRE  = 4;
	localparam int CTRL_START = 5;
	localparam int CTRL_COIN  = 6;

endpackage

`default_nettype wire

// ==== hw/audio_pkg.sv ====
//================================================
// Audio path constants
// Channel b carries four times the weight of channel a
//================================================
`default_nettype none

package audio_pkg;

	// One sound channel from the game core
	localparam int SND_W = 8;

	// Mixed sample, 255 + 4*255 = 1275 fits in 11 bits
	localparam int MIX_W       = 11;
	localparam int MIX_B_SHIFT = 2;

	// The accumulator matches the mix so the carry density equals mix / 2048
	localparam int ACC_W = MIX_W;

endpackage

`default_nettype wire

// ==== hw/ps2_receiver.sv ====
//================================================
// PS/2 device-to-host receiver, no host-to-device path
// Frames are checked on the stop bit and bad ones are dropped
// A partial frame is cleared after 65536 idle cycles
//================================================
`default_nettype none

module ps2_receiver import ctrl_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       ps2_kbd_clk,
	input  logic       ps2_kbd_data,
	output logic [7:0] scan_code,
	output logic       scan_valid
);

	logic [1:0]            clk_sync;
	logic [1:0]            data_sync;
	logic                  clk_prev;
	logic                  clk_fall;
	logic [PS2_BITS-1:0]   shift;
	logic [PS2_BITS-1:0]   frame;
	logic                  frame_ok;
	logic                  last_bit;
	logic [3:0]            bit_cnt;
	logic [PS2_WDOG_W-1:0] wdog;

	// Both lines idle high, so the synchronizers reset to 1
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_kbd_clk};
			data_sync <= {data_sync[0], ps2_kbd_data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[1];
	assign last_bit = (bit_cnt == 4'(PS2_BITS - 1));

	// Bits arrive LSB first, so the new bit enters at the top
	assign frame = {data_sync[1], shift[PS2_BITS-1:1]};

	// Start low, stop high and odd parity over data plus parity bit
	assign frame_ok = ~frame[0] & frame[PS2_BITS-1] & (^frame[9:1]);

	always_ff @(posedge clk_sys) begin
		if (clk_fall)
			shift <= frame;
		if (clk_fall && last_bit)
			scan_code <= frame[8:1];
	end

	//================================================
	// Bit counter, watchdog and output strobe
	//================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			bit_cnt    <= '0;
			wdog       <= '0;
			scan_valid <= 1'b0;
		end else begin
			scan_valid <= 1'b0;
			if (clk_fall) begin
				wdog <= '0;
				if (last_bit) begin
					bit_cnt    <= '0;
					scan_valid <= frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (bit_cnt != 4'd0) begin
				// Keyboard stalled mid-frame, start over on the next edge
				if (&wdog) begin
					bit_cnt <= '0;
					wdog    <= '0;
				end else begin
					wdog <= wdog + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/key_decoder.sv ====
//================================================
// Scancode to held key levels for eight cabinet keys
// Only set 2 make, F0 break and E0 extended codes are handled
//================================================
`default_nettype none

module key_decoder import ctrl_pkg::*; (
	input  logic             clk_sys,
	input  logic             rst,
	input  logic [7:0]       scan_code,
	input  logic             scan_valid,
	output logic [KEY_W-1:0] keys
);

	localparam int IDX_W = $clog2(KEY_W);

	logic             brk_flag;
	logic             ext_flag;
	logic             key_hit;
	logic [IDX_W-1:0] key_idx;

	// Arrows live in the extended page, the rest in the plain page
	always_comb begin
		key_hit = 1'b1;
		key_idx = '0;
		if (ext_flag) begin
			case (scan_code)
				SC_UP:    key_idx = IDX_W'(KEY_UP);
				SC_DOWN:  key_idx = IDX_W'(KEY_DOWN);
				SC_LEFT:  key_idx = IDX_W'(KEY_LEFT);
				SC_RIGHT: key_idx = IDX_W'(KEY_RIGHT);
				default:  key_hit = 1'b0;
			endcase
		end else begin
			case (scan_code)
				SC_SPACE: key_idx = IDX_W'(KEY_FIRE);
				SC_1:     key_idx = IDX_W'(KEY_START1);
				SC_2:     key_idx = IDX_W'(KEY_START2);
				SC_5:     key_idx = IDX_W'(KEY_COIN);
				default:  key_hit = 1'b0;
			endcase
		end
	end

	//================================================
	// Prefix flags and key state
	//================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			brk_flag <= 1'b0;
			ext_flag <= 1'b0;
			keys     <= '0;
		end else if (scan_valid) begin
			if (scan_code == SC_BREAK) begin
				brk_flag <= 1'b1;
			end else if (scan_code == SC_EXTENDED) begin
				ext_flag <= 1'b1;
			end else begin
				// Any other code ends the sequence, known or not
				if (key_hit)
					keys[key_idx] <= ~brk_flag;
				brk_flag <= 1'b0;
				ext_flag <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/control_mapper.sv ====
//================================================
// Merges keyboard and both joysticks into player controls
// Rotated mode turns the directions a quarter turn
// Player 2 has no coin input on this cabinet
//================================================
`default_nettype none

module control_mapper import ctrl_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst,
	input  logic [KEY_W-1:0]  keys,
	input  logic [7:0]        joystick_0,
	input  logic [7:0]        joystick_1,
	input  logic [31:0]       status,
	input  logic [1:0]        buttons,
	output logic [CTRL_W-1:0] p1_ctrl,
	output logic [CTRL_W-1:0] p2_ctrl,
	output logic              game_reset
);

	logic              src_up;
	logic              src_down;
	logic              src_left;
	logic              src_right;
	logic              src_fire;
	logic              rotate;
	logic [CTRL_W-1:0] shared_ctrl;
	logic [CTRL_W-1:0] p1_next;
	logic [CTRL_W-1:0] p2_next;

	// Every source is OR-ed, keyboard and both sticks alike
	assign src_up    = keys[KEY_UP] | joystick_0[JOY_UP] | joystick_1[JOY_UP];
	assign src_down  = keys[KEY_DOWN] | joystick_0[JOY_DOWN] | joystick_1[JOY_DOWN];
	assign src_left  = keys[KEY_LEFT] | joystick_0[JOY_LEFT] | joystick_1[JOY_LEFT];
	assign src_right = keys[KEY_RIGHT] | joystick_0[JOY_RIGHT] | joystick_1[JOY_RIGHT];
	assign src_fire  = keys[KEY_FIRE] | joystick_0[JOY_FIRE] | joystick_1[JOY_FIRE];
	assign rotate    = status[ST_ROTATE];

	always_comb begin
		shared_ctrl             = '0;
		shared_ctrl[CTRL_FIRE]  = src_fire;
		shared_ctrl[CTRL_UP]    = rotate ? src_right : src_up;
		shared_ctrl[CTRL_DOWN]  = rotate ? src_left  : src_down;
		shared_ctrl[CTRL_LEFT]  = rotate ? src_up    : src_left;
		shared_ctrl[CTRL_RIGHT] = rotate ? src_down  : src_right;

		p1_next             = shared_ctrl;
		p1_next[CTRL_COIN]  = keys[KEY_COIN];
		p1_next[CTRL_START] = keys[KEY_START1];

		p2_next             = shared_ctrl;
		p2_next[CTRL_START] = keys[KEY_START2];
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			p1_ctrl <= '0;
			p2_ctrl <= '0;
		end else begin
			p1_ctrl <= p1_next;
			p2_ctrl <= p2_next;
		end
	end

	// The system reset is one of the sources, so this goes high during rst
	always_ff @(posedge clk_sys)
		game_reset <= rst | status[ST_RESET] | status[ST_MENU_RESET] | buttons[BTN_RESET];

endmodule

`default_nettype wire

// ==== hw/audio_dac.sv ====
//================================================
// Two-channel mixer and first-order sigma-delta DAC
// Needs an external RC low-pass on the output pin
//================================================
`default_nettype none

module audio_dac import audio_pkg::*; (
	input  logic             clk_sys,
	input  logic             rst,
	input  logic [SND_W-1:0] audio_a,
	input  logic [SND_W-1:0] audio_b,
	output logic             dac_out
);

	logic [MIX_W-1:0] mix_next;
	logic [MIX_W-1:0] mix;
	logic [ACC_W-1:0] acc;
	logic [ACC_W:0]   acc_sum;

	// Channel b is weighted by four, channel a is added as is
	assign mix_next = {{(MIX_W - SND_W){1'b0}}, audio_a}
		+ {{(MIX_W - SND_W - MIX_B_SHIFT){1'b0}}, audio_b, {MIX_B_SHIFT{1'b0}}};

	assign acc_sum = {1'b0, acc} + {1'b0, mix};

	//================================================
	// Accumulator, the carry is the output bit
	//================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			mix     <= '0;
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			mix     <= mix_next;
			acc     <= acc_sum[ACC_W-1:0];
			dac_out <= acc_sum[ACC_W];
		end
	end

endmodule

`default_nettype wire

// ==== hw/cabinet_io.sv ====
//================================================
// Cabinet glue between the I/O controller and the game core
// All inputs must already be in the clk_sys domain except PS/2
//================================================
`default_nettype none

module cabinet_io import ctrl_pkg::*, audio_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst,
	input  logic              ps2_kbd_clk,
	input  logic              ps2_kbd_data,
	input  logic [7:0]        joystick_0,
	input  logic [7:0]        joystick_1,
	input  logic [31:0]       status,
	input  logic [1:0]        buttons,
	input  logic [SND_W-1:0]  audio_a,
	input  logic [SND_W-1:0]  audio_b,
	output logic [CTRL_W-1:0] p1_ctrl,
	output logic [CTRL_W-1:0] p2_ctrl,
	output logic              game_reset,
	output logic              audio_l,
	output logic              audio_r
);

	logic [7:0]       scan_code;
	logic             scan_valid;
	logic [KEY_W-1:0] keys;
	logic             dac_out;

	ps2_receiver u_ps2 (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.scan_code    (scan_code),
		.scan_valid   (scan_valid)
	);

	key_decoder u_keys (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.scan_code  (scan_code),
		.scan_valid (scan_valid),
		.keys       (keys)
	);

	control_mapper u_map (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.keys       (keys),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.buttons    (buttons),
		.p1_ctrl    (p1_ctrl),
		.p2_ctrl    (p2_ctrl),
		.game_reset (game_reset)
	);

	audio_dac u_dac (
		.clk_sys (clk_sys),
		.rst     (rst),
		.audio_a (audio_a),
		.audio_b (audio_b),
		.dac_out (dac_out)
	);

	// Mono source, both pins carry the same bit stream
	assign audio_l = dac_out;
	assign audio_r = dac_out;

endmodule

`default_nettype wire

// ==== tests/cabinet_io_assert.sv ====
//==================================================
// Cabinet glue properties, bound into cabinet_io
// fail_cnt holds the number of failed assertions
//==================================================
`default_nettype none

module cabinet_io_assert import ctrl_pkg::*; (
	input logic              clk_sys,
	input logic              rst,
	input logic              audio_l,
	input logic              audio_r,
	input logic              game_reset,
	input logic [CTRL_W-1:0] p2_ctrl
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0;

	// Both audio pins come from the same DAC bit
	audio_mono: assert property (@(posedge clk_sys) disable iff (rst) audio_r == audio_l)
		else begin
			fail_cnt++;
			$error("audio_r differs from audio_l");
		end

	reset_follows: assert property (@(posedge clk_sys) rst |=> game_reset)
		else begin
			fail_cnt++;
			$error("game_reset low in the cycle after rst");
		end

	// Player 2 has no coin on this cabinet
	p2_no_coin: assert property (@(posedge clk_sys) disable iff (rst) !p2_ctrl[CTRL_COIN])
		else begin
			fail_cnt++;
			$error("p2_ctrl coin bit is set");
		end

endmodule

bind cabinet_io cabinet_io_assert u_assert (
	.clk_sys    (clk_sys),
	.rst        (rst),
	.audio_l    (audio_l),
	.audio_r    (audio_r),
	.game_reset (game_reset),
	.p2_ctrl    (p2_ctrl)
);

`default_nettype wire

// ==== tests/cabinet_io_tb.sv ====
//==================================================
// Directed testbench for the cabinet glue
// PS/2 frames run at 40 clk_sys cycles per half period
//==================================================
`default_nettype none

module cabinet_io_tb import ctrl_pkg::*, audio_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic              clk_sys;
	logic              rst;
	logic              ps2_kbd_clk;
	logic              ps2_kbd_data;
	logic [7:0]        joystick_0;
	logic [7:0]        joystick_1;
	logic [31:0]       status;
	logic [1:0]        buttons;
	logic [SND_W-1:0]  audio_a;
	logic [SND_W-1:0]  audio_b;
	logic [CTRL_W-1:0] p1_ctrl;
	logic [CTRL_W-1:0] p2_ctrl;
	logic              game_reset;
	logic              audio_l;
	logic              audio_r;
	int                errors;
	integer            seed;

	cabinet_io u_dut (.*);

	always #2 clk_sys = ~clk_sys;

	//==================================================
	// Compare tasks and helpers
	//==================================================
	task automatic check_ctrl(input string name, input logic [CTRL_W-1:0] got,
		input logic [CTRL_W-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// A constant mix gives its count of ones within one either way
	task automatic check_count(input string name, input int got, input int exp);
		if (got > exp + 1 || got < exp - 1) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	function automatic logic [CTRL_W-1:0] one_hot(input int idx);
		return CTRL_W'(1) << idx;
	endfunction

	// Where a joystick bit lands in the control word, upright or rotated
	function automatic int joy_target(input int joy_bit, input logic rot);
		case (joy_bit)
			JOY_UP:    return rot ? CTRL_LEFT  : CTRL_UP;
			JOY_DOWN:  return rot ? CTRL_RIGHT : CTRL_DOWN;
			JOY_LEFT:  return rot ? CTRL_DOWN  : CTRL_LEFT;
			JOY_RIGHT: return rot ? CTRL_UP    : CTRL_RIGHT;
			default:   return CTRL_FIRE;
		endcase
	endfunction

	// Start, eight data bits LSB first, odd parity, stop
	task automatic send_ps2(input logic [7:0] code, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_kbd_data = frame[i];
			repeat (40) @(negedge clk_sys);
			ps2_kbd_clk = 1'b0;
			repeat (40) @(negedge clk_sys);
			ps2_kbd_clk = 1'b1;
		end
	endtask

	task automatic press_key(input logic [7:0] code, input logic extended);
		if (extended)
			send_ps2(SC_EXTENDED, 1'b0);
		send_ps2(code, 1'b0);
	endtask

	task automatic release_key(input logic [7:0] code, input logic extended);
		if (extended)
			send_ps2(SC_EXTENDED, 1'b0);
		send_ps2(SC_BREAK, 1'b0);
		send_ps2(code, 1'b0);
	endtask

	task automatic wait_ctrl(input logic [CTRL_W-1:0] exp1, input logic [CTRL_W-1:0] exp2);
		int n;
		n = 0;
		while ((p1_ctrl !== exp1 || p2_ctrl !== exp2) && n < 200) begin
			@(negedge clk_sys);
			n++;
		end
		if (p1_ctrl !== exp1 || p2_ctrl !== exp2)
			$display("Timed out after %0d cycles waiting for the control words", n);
		check_ctrl("p1_ctrl", p1_ctrl, exp1);
		check_ctrl("p2_ctrl", p2_ctrl, exp2);
	endtask

	task automatic report_test(input string name, input int start_errors);
		$display("%s finished with %0d errors", name, errors - start_errors);
	endtask

	//==================================================
	// Tests
	//==================================================
	task automatic test_keys_upright();
		int e0;
		e0 = errors;
		press_key(SC_SPACE, 1'b0);
		press_key(SC_5, 1'b0);
		press_key(SC_1, 1'b0);
		wait_ctrl(one_hot(CTRL_FIRE) | one_hot(CTRL_COIN) | one_hot(CTRL_START),
			one_hot(CTRL_FIRE));
		release_key(SC_SPACE, 1'b0);
		release_key(SC_5, 1'b0);
		release_key(SC_1, 1'b0);
		wait_ctrl('0, '0);
		press_key(SC_2, 1'b0);
		wait_ctrl('0, one_hot(CTRL_START));
		release_key(SC_2, 1'b0);
		wait_ctrl('0, '0);
		report_test("keys_upright", e0);
	endtask

	task automatic test_arrows_rotation();
		int e0;
		e0 = errors;
		press_key(SC_UP, 1'b1);
		wait_ctrl(one_hot(CTRL_UP), one_hot(CTRL_UP));
		status[ST_ROTATE] = 1'b1;
		wait_ctrl(one_hot(CTRL_LEFT), one_hot(CTRL_LEFT));
		release_key(SC_UP, 1'b1);
		wait_ctrl('0, '0);
		// Without the prefix 75h is not an arrow
		press_key(SC_UP, 1'b0);
		wait_ctrl('0, '0);
		status[ST_ROTATE] = 1'b0;
		report_test("arrows_rotation", e0);
	endtask

	task automatic test_joystick_merge();
		int e0;
		logic [CTRL_W-1:0] exp;
		e0 = errors;
		for (int r = 0; r < 2; r++) begin
			status[ST_ROTATE] = r[0];
			for (int j = 0; j <= JOY_FIRE; j++) begin
				exp = one_hot(joy_target(j, r[0]));
				joystick_0 = 8'd1 << j;
				wait_ctrl(exp, exp);
				joystick_0 = '0;
				wait_ctrl('0, '0);
				joystick_1 = 8'd1 << j;
				wait_ctrl(exp, exp);
				joystick_1 = '0;
				wait_ctrl('0, '0);
			end
		end
		status[ST_ROTATE] = 1'b0;
		report_test("joystick_merge", e0);
	endtask

	task automatic test_reset_sources();
		int e0;
		e0 = errors;
		for (int s = 0; s < 3; s++) begin
			status[ST_RESET]      = (s == 0);
			status[ST_MENU_RESET] = (s == 1);
			buttons[BTN_RESET]    = (s == 2);
			@(negedge clk_sys);
			check_bit("game_reset", game_reset, 1'b1);
			status[ST_RESET]      = 1'b0;
			status[ST_MENU_RESET] = 1'b0;
			buttons[BTN_RESET]    = 1'b0;
			@(negedge clk_sys);
			check_bit("game_reset", game_reset, 1'b0);
		end
		report_test("reset_sources", e0);
	endtask

	task automatic test_bad_frame();
		int e0;
		e0 = errors;
		send_ps2(SC_SPACE, 1'b1);
		wait_ctrl('0, '0);
		press_key(SC_SPACE, 1'b0);
		wait_ctrl(one_hot(CTRL_FIRE), one_hot(CTRL_FIRE));
		release_key(SC_SPACE, 1'b0);
		wait_ctrl('0, '0);
		report_test("bad_frame", e0);
	endtask

	task automatic test_dac_density();
		int e0;
		int ones_l;
		int ones_r;
		int exp_ones;
		e0 = errors;
		for (int t = 0; t < 4; t++) begin
			audio_a = $random(seed);
			audio_b = $random(seed);
			exp_ones = audio_a + 4 * audio_b;
			repeat (64) @(negedge clk_sys);
			ones_l = 0;
			ones_r = 0;
			repeat (2048) begin
				@(negedge clk_sys);
				ones_l += audio_l;
				ones_r += audio_r;
			end
			check_count("audio_l ones", ones_l, exp_ones);
			check_count("audio_r ones", ones_r, exp_ones);
		end
		audio_a = '0;
		audio_b = '0;
		report_test("dac_density", e0);
	endtask

	initial begin
		clk_sys      = 1'b0;
		rst          = 1'b1;
		ps2_kbd_clk  = 1'b1;
		ps2_kbd_data = 1'b1;
		joystick_0   = '0;
		joystick_1   = '0;
		status       = '0;
		buttons      = '0;
		audio_a      = '0;
		audio_b      = '0;
		errors       = 0;
		seed         = 32'h646a_916d;
		repeat (4) @(negedge clk_sys);
		rst = 1'b0;
		@(negedge clk_sys);
		test_keys_upright();
		test_arrows_rotation();
		test_joystick_merge();
		test_reset_sources();
		test_bad_frame();
		test_dac_density();
		errors += u_dut.u_assert.fail_cnt;
		$display("All tests done, %0d errors", errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
hw/ctrl_pkg.sv
hw/audio_pkg.sv
hw/ps2_receiver.sv
hw/key_decoder.sv
hw/control_mapper.sv
hw/audio_dac.sv
hw/cabinet_io.sv
tests/cabinet_io_assert.sv
tests/cabinet_io_tb.sv

// ==== Bender.yml ====
package:
  name: cabinet_io

sources:
  - hw/ctrl_pkg.sv
  - hw/audio_pkg.sv
  - hw/ps2_receiver.sv
  - hw/key_decoder.sv
  - hw/control_mapper.sv
  - hw/audio_dac.sv
  - hw/cabinet_io.sv
  - target: test
    files:
      - tests/cabinet_io_assert.sv
      - tests/cabinet_io_tb.sv
